// File: hdl/memsched_pkg.sv
`default_nettype none

package memsched_pkg;

    ////////////////////////////////////////////////////////////
    // Sizing
    ////////////////////////////////////////////////////////////
    localparam int NUM_QUEUES  = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int SLOT_CYCLES = 4;

    // Derived widths
    localparam int QUEUE_ID_W = $clog2(NUM_QUEUES);
    localparam int PTR_W      = $clog2(QUEUE_DEPTH);
    localparam int SLOT_CNT_W = $clog2(SLOT_CYCLES + 1);

    ////////////////////////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////////////////////////
    typedef logic [QUEUE_ID_W-1:0] queue_id_t;
    typedef logic [15:0]           payload_t;
    typedef logic [15:0]           time_t;
    typedef logic [3:0]            prio_t;
    typedef logic [3:0]            cfg_addr_t;
    typedef logic [PTR_W-1:0]      slot_ptr_t;
    // One extra bit so a full queue is distinct from an empty one
    typedef logic [PTR_W:0]        fill_t;
    typedef logic [SLOT_CNT_W-1:0] slot_cnt_t;

    ////////////////////////////////////////////////////////////
    // Configuration address map
    ////////////////////////////////////////////////////////////
    localparam cfg_addr_t CFG_DEADLINE_BASE = 4'd0;
    localparam cfg_addr_t CFG_PRIO_BASE     = 4'd4;
    // Bit 0 selects EDF, bit 1 is run
    localparam cfg_addr_t CFG_CONTROL       = 4'd8;

    typedef enum logic {
        MODE_FP  = 1'b0,
        MODE_EDF = 1'b1
    } sched_mode_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_SELECT = 2'd1,
        ST_ISSUE  = 2'd2,
        ST_WAIT   = 2'd3
    } sched_state_e;

endpackage

`default_nettype wire

// File: hdl/config_regs.sv
`timescale 1ns/10ps
`default_nettype none

module config_regs (
    input  logic                                                  clock,
    input  logic                                                  rst_n,
    input  logic                                                  cfg_we,
    input  memsched_pkg::cfg_addr_t                               cfg_addr,
    input  memsched_pkg::time_t                                   cfg_wdata,
    output memsched_pkg::time_t [memsched_pkg::NUM_QUEUES-1:0]    deadlines,
    output memsched_pkg::prio_t [memsched_pkg::NUM_QUEUES-1:0]    priorities,
    output memsched_pkg::sched_mode_e                             mode,
    output logic                                                  run
);
    import memsched_pkg::*;

    cfg_addr_t dl_off;
    cfg_addr_t pr_off;
    logic      dl_hit;
    logic      pr_hit;
    logic      ctl_hit;

    // Address decode, offsets wrap so one compare covers each window
    always_comb
    begin
        dl_off  = cfg_addr - CFG_DEADLINE_BASE;
        pr_off  = cfg_addr - CFG_PRIO_BASE;
        dl_hit  = cfg_we && (dl_off < cfg_addr_t'(NUM_QUEUES));
        pr_hit  = cfg_we && (pr_off < cfg_addr_t'(NUM_QUEUES));
        ctl_hit = cfg_we && (cfg_addr == CFG_CONTROL);
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            deadlines  <= '0;
            priorities <= '0;
            mode       <= MODE_FP;
            run        <= 1'b0;
        end
        else
        begin
            if (dl_hit)
                deadlines[queue_id_t'(dl_off)] <= cfg_wdata;
            // Priority field is the low nibble
            if (pr_hit)
                priorities[queue_id_t'(pr_off)] <= prio_t'(cfg_wdata);
            if (ctl_hit)
            begin
                mode <= sched_mode_e'(cfg_wdata[0]);
                run  <= cfg_wdata[1];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/request_queues.sv
`timescale 1ns/10ps
`default_nettype none

module request_queues (
    input  logic                                                  clock,
    input  logic                                                  rst_n,
    input  logic                                                  req_a_valid,
    input  logic                                                  req_b_valid,
    input  memsched_pkg::queue_id_t                               req_a_queue,
    input  memsched_pkg::queue_id_t                               req_b_queue,
    input  memsched_pkg::payload_t                                req_a_payload,
    input  memsched_pkg::payload_t                                req_b_payload,
    input  memsched_pkg::time_t                                   now,
    input  logic                                                  pop,
    input  memsched_pkg::queue_id_t                               pop_queue,
    output logic [memsched_pkg::NUM_QUEUES-1:0]                   not_empty,
    output memsched_pkg::time_t [memsched_pkg::NUM_QUEUES-1:0]    head_stamp,
    output memsched_pkg::payload_t [memsched_pkg::NUM_QUEUES-1:0] head_payload,
    output logic                                                  req_drop
);
    import memsched_pkg::*;

    // Circular buffers, one row per queue
    payload_t  pay_mem   [NUM_QUEUES][QUEUE_DEPTH];
    time_t     stamp_mem [NUM_QUEUES][QUEUE_DEPTH];
    slot_ptr_t rd_ptr    [NUM_QUEUES];
    slot_ptr_t wr_ptr    [NUM_QUEUES];
    fill_t     fill      [NUM_QUEUES];

    logic [NUM_QUEUES-1:0] pop_hit;
    logic [NUM_QUEUES-1:0] accept_a;
    logic [NUM_QUEUES-1:0] accept_b;
    slot_ptr_t             slot_b [NUM_QUEUES];
    logic                  drop_any;

    ////////////////////////////////////////////////////////////
    // Admission
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        int free_slots;
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            pop_hit[q] = pop && (pop_queue == queue_id_t'(q));
            // A pop this cycle frees its entry for the pushes
            free_slots = QUEUE_DEPTH - int'(fill[q]) + int'(pop_hit[q]);
            accept_a[q] = req_a_valid && (req_a_queue == queue_id_t'(q))
                          && (free_slots >= 1);
            // Port b lands behind port a
            accept_b[q] = req_b_valid && (req_b_queue == queue_id_t'(q))
                          && (free_slots >= 1 + int'(accept_a[q]));
            slot_b[q] = wr_ptr[q] + slot_ptr_t'(accept_a[q]);
        end
        // Each strobe targets exactly one queue
        drop_any = (req_a_valid && !(|accept_a)) || (req_b_valid && !(|accept_b));
    end

    ////////////////////////////////////////////////////////////
    // Pointers and fill levels
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                rd_ptr[q] <= '0;
                wr_ptr[q] <= '0;
                fill[q]   <= '0;
            end
            req_drop <= 1'b0;
        end
        else
        begin
            for (int q = 0; q < NUM_QUEUES; q++)
            begin
                rd_ptr[q] <= rd_ptr[q] + slot_ptr_t'(pop_hit[q]);
                wr_ptr[q] <= wr_ptr[q] + slot_ptr_t'(accept_a[q]) + slot_ptr_t'(accept_b[q]);
                fill[q]   <= fill[q] + fill_t'(accept_a[q]) + fill_t'(accept_b[q])
                             - fill_t'(pop_hit[q]);
            end
            req_drop <= drop_any;
        end
    end

    // Entry storage, stamped with the arrival time
    always_ff @(posedge clock)
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            if (accept_a[q])
            begin
                pay_mem[q][wr_ptr[q]]   <= req_a_payload;
                stamp_mem[q][wr_ptr[q]] <= now;
            end
            if (accept_b[q])
            begin
                pay_mem[q][slot_b[q]]   <= req_b_payload;
                stamp_mem[q][slot_b[q]] <= now;
            end
        end
    end

    always_comb
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            not_empty[q]    = (fill[q] != '0);
            head_payload[q] = pay_mem[q][rd_ptr[q]];
            head_stamp[q]   = stamp_mem[q][rd_ptr[q]];
        end
    end

    // Scheduler must only pop a queue holding data
    a_pop_not_empty: assert property (
        @(posedge clock) disable iff (!rst_n)
        pop |-> not_empty[pop_queue]
    );

endmodule

`default_nettype wire

// File: hdl/queue_selector.sv
`timescale 1ns/10ps
`default_nettype none

module queue_selector (
    input  logic [memsched_pkg::NUM_QUEUES-1:0]                   not_empty,
    input  memsched_pkg::time_t [memsched_pkg::NUM_QUEUES-1:0]    deadlines,
    input  memsched_pkg::prio_t [memsched_pkg::NUM_QUEUES-1:0]    priorities,
    input  memsched_pkg::time_t [memsched_pkg::NUM_QUEUES-1:0]    head_stamp,
    input  memsched_pkg::time_t                                   now,
    input  memsched_pkg::sched_mode_e                             mode,
    output memsched_pkg::queue_id_t                               pick_queue,
    output logic                                                  pick_valid
);
    import memsched_pkg::*;

    time_t slack [NUM_QUEUES];

    // Absolute deadline minus now, wrapping on the 16-bit time base
    always_comb
    begin
        for (int q = 0; q < NUM_QUEUES; q++)
            slack[q] = head_stamp[q] + deadlines[q] - now;
    end

    ////////////////////////////////////////////////////////////
    // Winner search
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        logic  better;
        prio_t best_prio;
        time_t best_slack;
        pick_valid = 1'b0;
        pick_queue = '0;
        best_prio  = '0;
        best_slack = '0;
        for (int q = 0; q < NUM_QUEUES; q++)
        begin
            // Strict compares keep ties on the lower index
            if (mode == MODE_EDF)
                better = !pick_valid || (slack[q] < best_slack);
            else
                better = !pick_valid || (priorities[q] > best_prio);
            if (not_empty[q] && better)
            begin
                pick_valid = 1'b1;
                pick_queue = queue_id_t'(q);
                best_prio  = priorities[q];
                best_slack = slack[q];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/slot_timer.sv
`timescale 1ns/10ps
`default_nettype none

module slot_timer (
    input  logic                clock,
    input  logic                rst_n,
    input  logic                slot_start,
    output memsched_pkg::time_t now,
    output logic                slot_done
);
    import memsched_pkg::*;

    slot_cnt_t count;

    // Time base and slot countdown
    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            now   <= '0;
            count <= '0;
        end
        else
        begin
            now <= now + time_t'(1);
            if (slot_start)
                count <= slot_cnt_t'(SLOT_CYCLES);
            else if (count != '0)
                count <= count - slot_cnt_t'(1);
        end
    end

    // High in the last countdown cycle
    // which is SLOT_CYCLES cycles after slot_start
    assign slot_done = (count == slot_cnt_t'(1));

    a_no_restart: assert property (
        @(posedge clock) disable iff (!rst_n)
        slot_start |-> (count == '0)
    );

endmodule

`default_nettype wire

// File: hdl/sched_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module sched_fsm (
    input  logic                                                  clock,
    input  logic                                                  rst_n,
    input  logic                                                  run,
    input  logic                                                  pick_valid,
    input  memsched_pkg::queue_id_t                               pick_queue,
    input  memsched_pkg::payload_t [memsched_pkg::NUM_QUEUES-1:0] head_payload,
    input  logic                                                  slot_done,
    output logic                                                  pop,
    output memsched_pkg::queue_id_t                               pop_queue,
    output logic                                                  slot_start,
    output logic                                                  mem_valid,
    output memsched_pkg::queue_id_t                               mem_queue,
    output memsched_pkg::payload_t                                mem_payload
);
    import memsched_pkg::*;

    sched_state_e state;
    sched_state_e state_next;
    logic         issue_q;

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE:
                if (run && pick_valid)
                    state_next = ST_SELECT;
            ST_SELECT:
                state_next = ST_ISSUE;
            ST_ISSUE:
                state_next = ST_WAIT;
            ST_WAIT:
                if (slot_done)
                    state_next = ST_IDLE;
            default:
                state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            state   <= ST_IDLE;
            issue_q <= 1'b0;
        end
        else
        begin
            state <= state_next;
            // High for exactly the ISSUE cycle
            issue_q <= (state == ST_SELECT);
        end
    end

    // Capture the pick so a late push cannot change the issued entry
    always_ff @(posedge clock)
    begin
        if (state == ST_SELECT)
        begin
            mem_queue   <= pick_queue;
            mem_payload <= head_payload[pick_queue];
        end
    end

    assign pop        = issue_q;
    assign pop_queue  = mem_queue;
    assign slot_start = issue_q;
    assign mem_valid  = issue_q;

    a_issue_state: assert property (
        @(posedge clock) disable iff (!rst_n)
        mem_valid |-> (state == ST_ISSUE)
    );

    // Slot spacing between successive issues
    a_issue_gap: assert property (
        @(posedge clock) disable iff (!rst_n)
        mem_valid |=> !mem_valid [*SLOT_CYCLES+1]
    );

endmodule

`default_nettype wire

// File: hdl/memsched_top.sv
`timescale 1ns/10ps
`default_nettype none

module memsched_top (
    input  logic                          clock,
    input  logic                          rst_n,
    // Requester ports
    input  logic                          req_a_valid,
    input  memsched_pkg::queue_id_t       req_a_queue,
    input  memsched_pkg::payload_t        req_a_payload,
    input  logic                          req_b_valid,
    input  memsched_pkg::queue_id_t       req_b_queue,
    input  memsched_pkg::payload_t        req_b_payload,
    output logic                          req_drop,
    // Configuration
    input  logic                          cfg_we,
    input  memsched_pkg::cfg_addr_t       cfg_addr,
    input  memsched_pkg::time_t           cfg_wdata,
    // Memory side
    output logic                          mem_valid,
    output memsched_pkg::queue_id_t       mem_queue,
    output memsched_pkg::payload_t        mem_payload
);
    import memsched_pkg::*;

    time_t    [NUM_QUEUES-1:0] deadlines;
    prio_t    [NUM_QUEUES-1:0] priorities;
    sched_mode_e               mode;
    logic                      run;

    logic     [NUM_QUEUES-1:0] not_empty;
    time_t    [NUM_QUEUES-1:0] head_stamp;
    payload_t [NUM_QUEUES-1:0] head_payload;

    queue_id_t                 pick_queue;
    logic                      pick_valid;
    logic                      pop;
    queue_id_t                 pop_queue;
    logic                      slot_start;
    logic                      slot_done;
    time_t                     now;

    config_regs config_regs_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .deadlines  (deadlines),
        .priorities (priorities),
        .mode       (mode),
        .run        (run)
    );

    request_queues request_queues_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .req_a_valid   (req_a_valid),
        .req_b_valid   (req_b_valid),
        .req_a_queue   (req_a_queue),
        .req_b_queue   (req_b_queue),
        .req_a_payload (req_a_payload),
        .req_b_payload (req_b_payload),
        .now           (now),
        .pop           (pop),
        .pop_queue     (pop_queue),
        .not_empty     (not_empty),
        .head_stamp    (head_stamp),
        .head_payload  (head_payload),
        .req_drop      (req_drop)
    );

    queue_selector queue_selector_i (
        .not_empty  (not_empty),
        .deadlines  (deadlines),
        .priorities (priorities),
        .head_stamp (head_stamp),
        .now        (now),
        .mode       (mode),
        .pick_queue (pick_queue),
        .pick_valid (pick_valid)
    );

    slot_timer slot_timer_i (
        .clock      (clock),
        .rst_n      (rst_n),
        .slot_start (slot_start),
        .now        (now),
        .slot_done  (slot_done)
    );

    sched_fsm sched_fsm_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .run          (run),
        .pick_valid   (pick_valid),
        .pick_queue   (pick_queue),
        .head_payload (head_payload),
        .slot_done    (slot_done),
        .pop          (pop),
        .pop_queue    (pop_queue),
        .slot_start   (slot_start),
        .mem_valid    (mem_valid),
        .mem_queue    (mem_queue),
        .mem_payload  (mem_payload)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    output logic clock
);

    // 100 ns period, low for the first half
    initial
    begin
        clock = 1'b0;
    end

    always
    begin
        #50 clock = ~clock;
    end

endmodule

`default_nettype wire

// File: tests/memsched_tb.sv
`timescale 1ns/10ps
`default_nettype none

module memsched_tb;
    import memsched_pkg::*;

    typedef enum int {
        K_CFG, K_PUSH_A, K_PUSH_B, K_PUSH_AB, K_IDLE, K_RUN, K_EXPECT, K_END
    } row_kind_e;

    logic        clock;
    logic        rst_n;
    logic        req_a_valid;
    queue_id_t   req_a_queue;
    payload_t    req_a_payload;
    logic        req_b_valid;
    queue_id_t   req_b_queue;
    payload_t    req_b_payload;
    logic        req_drop;
    logic        cfg_we;
    cfg_addr_t   cfg_addr;
    time_t       cfg_wdata;
    logic        mem_valid;
    queue_id_t   mem_queue;
    payload_t    mem_payload;

    // Case table, one row per step
    row_kind_e   row_kind   [80];
    logic [3:0]  row_sel    [80];
    logic [15:0] row_data_a [80];
    logic [15:0] row_data_b [80];
    int          row_count;

    int          mismatch_count;
    int          timeout_count;
    int          drop_count;
    int          drop_base;
    int          case_index;
    int          issue_limit = 40;

    tb_clock tb_clock_i (
        .clock (clock)
    );

    memsched_top memsched_top_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .req_a_valid   (req_a_valid),
        .req_a_queue   (req_a_queue),
        .req_a_payload (req_a_payload),
        .req_b_valid   (req_b_valid),
        .req_b_queue   (req_b_queue),
        .req_b_payload (req_b_payload),
        .req_drop      (req_drop),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .mem_valid     (mem_valid),
        .mem_queue     (mem_queue),
        .mem_payload   (mem_payload)
    );

    // Drop pulse counter
    always @(posedge clock)
    begin
        if (rst_n && req_drop)
            drop_count <= drop_count + 1;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task add_row(input row_kind_e kind, input logic [3:0] sel,
                 input logic [15:0] data_a, input logic [15:0] data_b);
        row_kind[row_count]   = kind;
        row_sel[row_count]    = sel;
        row_data_a[row_count] = data_a;
        row_data_b[row_count] = data_b;
        row_count++;
    endtask

    task check_value(input string what, input logic [31:0] actual,
                     input logic [31:0] expected);
        if (actual !== expected)
        begin
            mismatch_count++;
            $display("MISMATCH at time %0t: case %0d %s is 0x%0h, expected 0x%0h",
                     $time, case_index, what, actual, expected);
        end
    endtask

    task clear_strobes;
        req_a_valid <= 1'b0;
        req_b_valid <= 1'b0;
        cfg_we      <= 1'b0;
    endtask

    // One edge with no issue allowed
    task step_quiet;
        @(posedge clock);
        check_value("mem_valid", 32'(mem_valid), 32'd0);
        clear_strobes();
    endtask

    task quiet_window(input int cycles);
        for (int i = 0; i < cycles; i++)
            step_quiet();
    endtask

    task write_cfg(input cfg_addr_t addr, input time_t data);
        step_quiet();
        cfg_we    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
    endtask

    task push(input logic use_a, input logic use_b, input queue_id_t q,
              input payload_t pay_a, input payload_t pay_b);
        step_quiet();
        if (use_a)
        begin
            req_a_valid   <= 1'b1;
            req_a_queue   <= q;
            req_a_payload <= pay_a;
        end
        if (use_b)
        begin
            req_b_valid   <= 1'b1;
            req_b_queue   <= q;
            req_b_payload <= pay_b;
        end
    endtask

    task wait_issue(input queue_id_t q, input payload_t payload);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < issue_limit)
        begin
            @(posedge clock);
            clear_strobes();
            cycles++;
            if (mem_valid === 1'b1)
                seen = 1'b1;
        end
        if (!seen)
        begin
            timeout_count++;
            $display("Timeout: case %0d saw no memory issue within %0d cycles",
                     case_index, issue_limit);
        end
        else
        begin
            check_value("mem_queue", 32'(mem_queue), 32'(q));
            check_value("mem_payload", 32'(mem_payload), 32'(payload));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Cases
    ////////////////////////////////////////////////////////////
    task build_table;
        row_count = 0;
        // Push order within a queue, port a ahead of port b, FP ties
        add_row(K_PUSH_A,  4'd2, 16'h1001, 16'h0000);
        add_row(K_PUSH_B,  4'd0, 16'h0000, 16'h2001);
        add_row(K_PUSH_A,  4'd2, 16'h1002, 16'h0000);
        add_row(K_PUSH_AB, 4'd2, 16'h1003, 16'h1004);
        add_row(K_IDLE,    4'd0, 16'd12,   16'h0000);
        add_row(K_RUN,     4'd0, 16'd0,    16'h0000);
        add_row(K_EXPECT,  4'd0, 16'h2001, 16'h0000);
        add_row(K_EXPECT,  4'd2, 16'h1001, 16'h0000);
        add_row(K_EXPECT,  4'd2, 16'h1002, 16'h0000);
        add_row(K_EXPECT,  4'd2, 16'h1003, 16'h0000);
        add_row(K_EXPECT,  4'd2, 16'h1004, 16'h0000);
        add_row(K_END,     4'd0, 16'd0,    16'h0000);
        // Fixed priority, queue 1 and 2 tie at 7
        add_row(K_CFG,     4'd4, 16'd2,    16'h0000);
        add_row(K_CFG,     4'd5, 16'd7,    16'h0000);
        add_row(K_CFG,     4'd6, 16'd7,    16'h0000);
        add_row(K_CFG,     4'd7, 16'd9,    16'h0000);
        add_row(K_PUSH_A,  4'd0, 16'h3001, 16'h0000);
        add_row(K_PUSH_B,  4'd2, 16'h0000, 16'h3201);
        add_row(K_PUSH_A,  4'd1, 16'h3101, 16'h0000);
        add_row(K_PUSH_B,  4'd3, 16'h0000, 16'h3301);
        add_row(K_PUSH_A,  4'd1, 16'h3102, 16'h0000);
        add_row(K_PUSH_A,  4'd3, 16'h3302, 16'h0000);
        add_row(K_RUN,     4'd0, 16'd0,    16'h0000);
        add_row(K_EXPECT,  4'd3, 16'h3301, 16'h0000);
        add_row(K_EXPECT,  4'd3, 16'h3302, 16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h3101, 16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h3102, 16'h0000);
        add_row(K_EXPECT,  4'd2, 16'h3201, 16'h0000);
        add_row(K_EXPECT,  4'd0, 16'h3001, 16'h0000);
        add_row(K_END,     4'd0, 16'd0,    16'h0000);
        // EDF, deadlines 400 100 300 200
        add_row(K_CFG,     4'd0, 16'd400,  16'h0000);
        add_row(K_CFG,     4'd1, 16'd100,  16'h0000);
        add_row(K_CFG,     4'd2, 16'd300,  16'h0000);
        add_row(K_CFG,     4'd3, 16'd200,  16'h0000);
        add_row(K_PUSH_A,  4'd0, 16'h4000, 16'h0000);
        add_row(K_PUSH_B,  4'd1, 16'h0000, 16'h4100);
        add_row(K_PUSH_A,  4'd2, 16'h4200, 16'h0000);
        add_row(K_PUSH_B,  4'd3, 16'h0000, 16'h4300);
        add_row(K_RUN,     4'd0, 16'd1,    16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h4100, 16'h0000);
        add_row(K_EXPECT,  4'd3, 16'h4300, 16'h0000);
        add_row(K_EXPECT,  4'd2, 16'h4200, 16'h0000);
        add_row(K_EXPECT,  4'd0, 16'h4000, 16'h0000);
        add_row(K_END,     4'd0, 16'd0,    16'h0000);
        // Overflow, fifth push is dropped
        add_row(K_PUSH_A,  4'd1, 16'h5001, 16'h0000);
        add_row(K_PUSH_A,  4'd1, 16'h5002, 16'h0000);
        add_row(K_PUSH_A,  4'd1, 16'h5003, 16'h0000);
        add_row(K_PUSH_A,  4'd1, 16'h5004, 16'h0000);
        add_row(K_PUSH_A,  4'd1, 16'h5005, 16'h0000);
        add_row(K_RUN,     4'd0, 16'd0,    16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h5001, 16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h5002, 16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h5003, 16'h0000);
        add_row(K_EXPECT,  4'd1, 16'h5004, 16'h0000);
        add_row(K_END,     4'd0, 16'd1,    16'h0000);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        rst_n         <= 1'b0;
        req_a_valid   <= 1'b0;
        req_a_queue   <= '0;
        req_a_payload <= '0;
        req_b_valid   <= 1'b0;
        req_b_queue   <= '0;
        req_b_payload <= '0;
        cfg_we        <= 1'b0;
        cfg_addr      <= '0;
        cfg_wdata     <= '0;
        mismatch_count = 0;
        timeout_count  = 0;
        drop_base      = 0;
        case_index     = 0;
        build_table();
        repeat (5) @(posedge clock);
        rst_n <= 1'b1;

        for (int r = 0; r < row_count; r++)
        begin
            case (row_kind[r])
                K_CFG:
                    write_cfg(cfg_addr_t'(row_sel[r]), row_data_a[r]);
                K_PUSH_A:
                    push(1'b1, 1'b0, queue_id_t'(row_sel[r]), row_data_a[r], row_data_b[r]);
                K_PUSH_B:
                    push(1'b0, 1'b1, queue_id_t'(row_sel[r]), row_data_a[r], row_data_b[r]);
                K_PUSH_AB:
                    push(1'b1, 1'b1, queue_id_t'(row_sel[r]), row_data_a[r], row_data_b[r]);
                K_IDLE:
                    quiet_window(int'(row_data_a[r]));
                // Control word, run in bit 1, mode from the table
                K_RUN:
                    write_cfg(CFG_CONTROL, 16'h0002 | row_data_a[r]);
                K_EXPECT:
                    wait_issue(queue_id_t'(row_sel[r]), row_data_a[r]);
                K_END:
                begin
                    quiet_window(20);
                    write_cfg(CFG_CONTROL, 16'h0000);
                    step_quiet();
                    check_value("drop pulses", 32'(drop_count - drop_base),
                                32'(row_data_a[r]));
                    drop_base = drop_count;
                    case_index++;
                end
                default:
                    step_quiet();
            endcase
        end

        $display("Summary: %0d cases, %0d mismatches, %0d timeouts",
                 case_index, mismatch_count, timeout_count);
        if (mismatch_count + timeout_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hdl/memsched_pkg.sv
hdl/config_regs.sv
hdl/request_queues.sv
hdl/queue_selector.sv
hdl/slot_timer.sv
hdl/sched_fsm.sv
hdl/memsched_top.sv
tests/tb_clock.sv
tests/memsched_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memsched regression with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module memsched_tb

sim_output=$(./obj_dir/Vmemsched_tb)
echo "$sim_output"

# Pass only when the testbench printed its pass line
echo "$sim_output" | grep -qx "Regression passed"
